//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

  // datapath and pc width
  localparam int XLEN = 32;
  // instruction word width
  localparam int INST_LEN = 32;
  // x0..x31
  localparam int REG_ADDRWIDTH = 5;

  // addi x0,x0,0
  localparam logic [INST_LEN-1:0] INST_NOP = 32'h0000_0013;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  // funct3 of register and immediate alu forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  // srl or sra, picked by inst[30]
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 of the conditional branches kept here
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  // alu operation carried by a micro-op
  typedef enum logic [3:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_e;

  // branch compare, jal is unconditional
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_JAL
  } br_op_e;

endpackage

//--- source/pipe_pkg.sv
package pipe_pkg;

  // stage registers between decode and execute
  localparam int PIPE_DEPTH = 3;

  // one decoded instruction in flight
  typedef struct packed {
    logic                                valid;
    logic [rv_isa_pkg::XLEN-1:0]          pc;
    logic [rv_isa_pkg::INST_LEN-1:0]      inst;
    logic [rv_isa_pkg::REG_ADDRWIDTH-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]          imm;
    logic [rv_isa_pkg::XLEN-1:0]          rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]          rs2_data;
    rv_isa_pkg::alu_op_e                  alu_op;
    rv_isa_pkg::br_op_e                   br_op;
    logic                                use_imm;
  } uop_t;

  // bubble loaded by reset and flush
  localparam uop_t UOP_NOP = '{
    valid:    1'b0,
    pc:       '0,
    inst:     rv_isa_pkg::INST_NOP,
    rd:       '0,
    imm:      '0,
    rs1_data: '0,
    rs2_data: '0,
    alu_op:   rv_isa_pkg::ALU_NONE,
    br_op:    rv_isa_pkg::BR_NONE,
    use_imm:  1'b0
  };

  // one bit per stage, bit 0 is the entry stage
  typedef logic [PIPE_DEPTH-1:0] stage_vec_t;

endpackage

//--- source/inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
  input  logic                              issue_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       pc_i,
  input  logic [rv_isa_pkg::INST_LEN-1:0]   inst_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs2_data_i,
  output pipe_pkg::uop_t                    uop_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  // inst[30] selects sub and sra
  logic            alt_bit;
  logic            supported;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign opcode  = opcode_e'(inst_i[6:0]);
  assign funct3  = inst_i[14:12];
  assign alt_bit = inst_i[30];

  // immediate formats
  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // funct3 map shared by register and immediate forms
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    uop_o          = UOP_NOP;
    uop_o.pc       = pc_i;
    uop_o.inst     = inst_i;
    uop_o.rd       = inst_i[11:7];
    uop_o.rs1_data = rs1_data_i;
    uop_o.rs2_data = rs2_data_i;
    supported      = 1'b1;
    case (opcode)
      OP: begin
        uop_o.alu_op = alu_sel(funct3, alt_bit);
      end
      OP_IMM: begin
        // no subi, inst[30] only matters for shifts
        uop_o.alu_op  = alu_sel(funct3, alt_bit & (funct3 == F3_SR));
        uop_o.imm     = imm_i;
        uop_o.use_imm = 1'b1;
      end
      LUI: begin
        uop_o.alu_op  = ALU_LUI;
        uop_o.imm     = imm_u;
        uop_o.use_imm = 1'b1;
      end
      BRANCH: begin
        // conditional branches write no register
        uop_o.rd  = '0;
        uop_o.imm = imm_b;
        case (funct3)
          F3_BEQ:  uop_o.br_op = BR_EQ;
          F3_BNE:  uop_o.br_op = BR_NE;
          F3_BLT:  uop_o.br_op = BR_LT;
          F3_BGE:  uop_o.br_op = BR_GE;
          // unsigned compares not carried
          default: supported = 1'b0;
        endcase
      end
      JAL: begin
        uop_o.imm   = imm_j;
        uop_o.br_op = BR_JAL;
      end
      default: begin
        supported = 1'b0;
      end
    endcase
    // unsupported word travels as a bubble
    uop_o.valid = issue_valid_i & supported;
  end

endmodule

//--- source/pipe_stage_reg.sv
`timescale 1ns/10ps

module pipe_stage_reg (
  input  logic           clk,
  input  logic           rst_i,
  input  logic           hold_i,
  input  logic           flush_i,
  input  pipe_pkg::uop_t uop_i,
  output pipe_pkg::uop_t uop_o
);
  import pipe_pkg::*;

  logic clear;

  // reset and flush both leave a bubble
  assign clear = rst_i | flush_i;

  always_ff @(posedge clk) begin
    if (clear) begin
      uop_o <= UOP_NOP;
    end else if (!hold_i) begin
      uop_o <= uop_i;
    end
  end

endmodule

//--- source/pipe_ctrl.sv
`timescale 1ns/10ps

module pipe_ctrl (
  input  logic                stall_i,
  input  logic                branch_taken_i,
  input  pipe_pkg::stage_vec_t stage_valid_i,
  output pipe_pkg::stage_vec_t hold_o,
  output pipe_pkg::stage_vec_t flush_o,
  output logic                issue_ready_o
);
  import pipe_pkg::*;

  logic flush_all;

  // a stalled execute unit keeps the branch in place
  assign flush_all = branch_taken_i & ~stall_i;
  assign flush_o   = {PIPE_DEPTH{flush_all}};

  // walk from the last stage back to the entry stage
  always_comb begin
    logic full_tail;
    full_tail = stall_i;
    for (int k = PIPE_DEPTH - 1; k >= 0; k--) begin
      // held only if this stage and all after it are occupied
      full_tail = full_tail & stage_valid_i[k];
      // flush has priority
      hold_o[k] = full_tail & ~flush_all;
    end
  end

  // entry stage must be free to take a new word
  assign issue_ready_o = ~hold_o[0] & ~flush_o[0];

endmodule

//--- source/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic                                  stall_i,
  input  pipe_pkg::uop_t                        uop_i,
  output logic                                  branch_taken_o,
  output logic                                  result_valid_o,
  output logic [rv_isa_pkg::REG_ADDRWIDTH-1:0]  rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]           result_o,
  output logic [rv_isa_pkg::XLEN-1:0]           res_pc_o,
  output logic                                  redirect_o,
  output logic [rv_isa_pkg::XLEN-1:0]           redirect_pc_o
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] result_d;
  logic            rs_eq;
  logic            rs_lt;
  logic            cond;

  assign op_a  = uop_i.rs1_data;
  assign op_b  = uop_i.use_imm ? uop_i.imm : uop_i.rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (uop_i.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SLT:  alu_res = {{(XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN - 1){1'b0}}, op_a < op_b};
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
      // immediate already shifted into place
      ALU_LUI:  alu_res = op_b;
      default:  alu_res = '0;
    endcase
  end

  // branch compare always on the two registers
  assign rs_eq = uop_i.rs1_data == uop_i.rs2_data;
  assign rs_lt = $signed(uop_i.rs1_data) < $signed(uop_i.rs2_data);

  always_comb begin
    case (uop_i.br_op)
      BR_EQ:   cond = rs_eq;
      BR_NE:   cond = ~rs_eq;
      BR_LT:   cond = rs_lt;
      BR_GE:   cond = ~rs_lt;
      BR_JAL:  cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken_o = uop_i.valid & cond;

  // branches and jal report the link value
  assign result_d = (uop_i.br_op != BR_NONE) ? uop_i.pc + 32'd4 : alu_res;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      result_valid_o <= 1'b0;
      redirect_o     <= 1'b0;
    end else begin
      if (!stall_i) begin
        result_valid_o <= uop_i.valid;
      end
      // single pulse, never raised while stalled
      redirect_o <= branch_taken_o & ~stall_i;
    end
  end

  // result fields frozen under stall
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      rd_o          <= uop_i.rd;
      result_o      <= result_d;
      res_pc_o      <= uop_i.pc;
      redirect_pc_o <= uop_i.pc + uop_i.imm;
    end
  end

endmodule

//--- source/core_pipe_top.sv
`timescale 1ns/10ps

module core_pipe_top (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic                                  issue_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0]           pc_i,
  input  logic [rv_isa_pkg::INST_LEN-1:0]       inst_i,
  input  logic [rv_isa_pkg::XLEN-1:0]           rs1_data_i,
  input  logic [rv_isa_pkg::XLEN-1:0]           rs2_data_i,
  input  logic                                  stall_i,
  output logic                                  issue_ready_o,
  output logic                                  result_valid_o,
  output logic [rv_isa_pkg::REG_ADDRWIDTH-1:0]  rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]           result_o,
  output logic [rv_isa_pkg::XLEN-1:0]           res_pc_o,
  output logic                                  redirect_o,
  output logic [rv_isa_pkg::XLEN-1:0]           redirect_pc_o
);
  import pipe_pkg::*;

  // chain[0] from decode, chain[k+1] out of stage k
  uop_t       chain [PIPE_DEPTH+1];
  stage_vec_t stage_valid;
  stage_vec_t hold;
  stage_vec_t flush;
  logic       branch_taken;

  inst_decode u_inst_decode (
    .issue_valid_i (issue_valid_i),
    .pc_i          (pc_i),
    .inst_i        (inst_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .uop_o         (chain[0])
  );

  for (genvar k = 0; k < PIPE_DEPTH; k++) begin : g_stage
    pipe_stage_reg u_stage (
      .clk     (clk),
      .rst_i   (rst_i),
      .hold_i  (hold[k]),
      .flush_i (flush[k]),
      .uop_i   (chain[k]),
      .uop_o   (chain[k+1])
    );
    // occupancy seen by the control unit
    assign stage_valid[k] = chain[k+1].valid;
  end

  pipe_ctrl u_pipe_ctrl (
    .stall_i        (stall_i),
    .branch_taken_i (branch_taken),
    .stage_valid_i  (stage_valid),
    .hold_o         (hold),
    .flush_o        (flush),
    .issue_ready_o  (issue_ready_o)
  );

  // last stage drains into execute
  exec_unit u_exec_unit (
    .clk            (clk),
    .rst_i          (rst_i),
    .stall_i        (stall_i),
    .uop_i          (chain[PIPE_DEPTH]),
    .branch_taken_o (branch_taken),
    .result_valid_o (result_valid_o),
    .rd_o           (rd_o),
    .result_o       (result_o),
    .res_pc_o       (res_pc_o),
    .redirect_o     (redirect_o),
    .redirect_pc_o  (redirect_pc_o)
  );

endmodule

//--- tb/core_pipe_props.sv
`timescale 1ns/10ps

// control unit rules, sampled at the top where the clock lives
module core_pipe_props (
  input logic                 clk,
  input logic                 rst_i,
  input logic                 stall_i,
  input pipe_pkg::stage_vec_t hold_i,
  input pipe_pkg::stage_vec_t flush_i,
  input logic                 issue_ready_i
);

  // flush has priority over every hold bit
  a_flush_no_hold: assert property (@(posedge clk) disable iff (rst_i)
    (|flush_i) |-> (hold_i == '0))
    else $error("hold bit set while the stages flush");

  // nothing enters a flushing pipe
  a_flush_not_ready: assert property (@(posedge clk) disable iff (rst_i)
    (|flush_i) |-> !issue_ready_i)
    else $error("issue ready high during a flush");

  // holds only come from back-pressure
  a_no_hold_unstalled: assert property (@(posedge clk) disable iff (rst_i)
    !stall_i |-> (hold_i == '0))
    else $error("stage held with stall low");

endmodule

bind core_pipe_top core_pipe_props u_props (
  .clk           (clk),
  .rst_i         (rst_i),
  .stall_i       (stall_i),
  .hold_i        (hold),
  .flush_i       (flush),
  .issue_ready_i (issue_ready_o)
);

//--- tb/core_pipe_tb.sv
`timescale 1ns/10ps

module core_pipe_tb;
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int N_ALU = 60;
  localparam int N_MIX = 300;
  // accept edge loads stage 0, later stages and execute add one edge each
  localparam int LATENCY = PIPE_DEPTH;
  localparam int TIMEOUT_CYCLES = (N_ALU + N_MIX) * (PIPE_DEPTH + 8) + 50;

  // expected outcome of one accepted instruction
  typedef struct packed {
    logic                     valid;
    logic                     taken;
    logic [REG_ADDRWIDTH-1:0] rd;
    logic [XLEN-1:0]          pc;
    logic [XLEN-1:0]          result;
    logic [XLEN-1:0]          target;
    logic [31:0]              acc_edge;
    logic [31:0]              stall_snap;
  } exp_t;

  logic                     clk = 1'b0;
  logic                     rst_i;
  logic                     issue_valid_i;
  logic [XLEN-1:0]          pc_i;
  logic [INST_LEN-1:0]      inst_i;
  logic [XLEN-1:0]          rs1_data_i;
  logic [XLEN-1:0]          rs2_data_i;
  logic                     stall_i;
  logic                     issue_ready_o;
  logic                     result_valid_o;
  logic [REG_ADDRWIDTH-1:0] rd_o;
  logic [XLEN-1:0]          result_o;
  logic [XLEN-1:0]          res_pc_o;
  logic                     redirect_o;
  logic [XLEN-1:0]          redirect_pc_o;

  logic [31:0]              rng_state = 32'd74264;
  logic [31:0]              cyc = 32'd0;
  logic [31:0]              stall_edges = 32'd0;
  logic [XLEN-1:0]          next_pc = 32'h0000_1000;
  exp_t                     exp_q [$];
  int                       n_value_err = 0;
  int                       n_other_err = 0;
  int                       n_checked = 0;
  // previous cycle as seen by the compare process
  logic                     prev_valid = 1'b0;
  logic                     prev_stall = 1'b0;
  logic [REG_ADDRWIDTH-1:0] prev_rd;
  logic [XLEN-1:0]          prev_result;
  logic [XLEN-1:0]          prev_pc;
  logic                     redirect_seen = 1'b0;

  core_pipe_top dut0 (
    .clk            (clk),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .pc_i           (pc_i),
    .inst_i         (inst_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .stall_i        (stall_i),
    .issue_ready_o  (issue_ready_o),
    .result_valid_o (result_valid_o),
    .rd_o           (rd_o),
    .result_o       (result_o),
    .res_pc_o       (res_pc_o),
    .redirect_o     (redirect_o),
    .redirect_pc_o  (redirect_pc_o)
  );

  always #HALF_PERIOD clk = ~clk;

  // edge counter, read half a period later
  always @(posedge clk) cyc <= cyc + 32'd1;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // rv32i integer ops, alt is inst[30] where it selects sub or sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b010:  r = {31'b0, $signed(a) < $signed(b)};
      3'b011:  r = {31'b0, a < b};
      3'b100:  r = a ^ b;
      3'b101: begin
        r = a >> b[4:0];
        // sra refills the vacated top bits with the sign
        if (alt) r = r | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
      end
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // expected result straight from the instruction encoding
  function automatic exp_t ref_model(input logic [31:0] pc, input logic [31:0] inst,
                                     input logic [31:0] a, input logic [31:0] b);
    exp_t        e;
    logic [2:0]  f3;
    logic [31:0] imm;
    e       = '0;
    e.valid = 1'b1;
    e.pc    = pc;
    e.rd    = inst[11:7];
    f3      = inst[14:12];
    case (inst[6:0])
      7'b0110011: e.result = alu_ref(f3, inst[30], a, b);
      7'b0010011: begin
        imm      = {{20{inst[31]}}, inst[31:20]};
        e.result = alu_ref(f3, inst[30] && (f3 == 3'b101), a, imm);
      end
      7'b0110111: e.result = {inst[31:12], 12'b0};
      7'b1100011: begin
        imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        e.rd     = '0;
        e.result = pc + 32'd4;
        e.target = pc + imm;
        case (f3)
          3'b000:  e.taken = (a == b);
          3'b001:  e.taken = (a != b);
          3'b100:  e.taken = ($signed(a) < $signed(b));
          3'b101:  e.taken = ($signed(a) >= $signed(b));
          // bltu and bgeu dropped by the decoder
          default: e.valid = 1'b0;
        endcase
      end
      7'b1101111: begin
        imm      = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        e.result = pc + 32'd4;
        e.target = pc + imm;
        e.taken  = 1'b1;
      end
      default: e.valid = 1'b0;
    endcase
    return e;
  endfunction

  // random instruction, alu_only keeps to op, op-imm and lui
  function automatic logic [31:0] make_inst(input logic alu_only);
    logic [31:0] r;
    logic [31:0] f;
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] inst;
    r    = xorshift32();
    f    = xorshift32();
    kind = r[3:0];
    f3   = r[9:7];
    alt  = r[10];
    if (alu_only && kind > 4'd9) kind = {1'b0, r[6:4]};
    if (kind <= 4'd4 || kind >= 4'd14) begin
      inst = {1'b0, alt & (f3 == 3'd0 || f3 == 3'd5), 5'b0, f[24:20], f[19:15], f3,
              f[11:7], 7'b0110011};
    end else if (kind <= 4'd8) begin
      if (f3 == 3'd1 || f3 == 3'd5)
        inst = {1'b0, alt & (f3 == 3'd5), 5'b0, f[24:20], f[19:15], f3, f[11:7], 7'b0010011};
      else
        inst = {f[31:20], f[19:15], f3, f[11:7], 7'b0010011};
    end else if (kind == 4'd9) begin
      inst = {f[31:12], f[11:7], 7'b0110111};
    end else if (kind <= 4'd11) begin
      inst = {f[31:15], f3, f[11:7], 7'b1100011};
    end else if (kind == 4'd12) begin
      inst = {f[31:12], f[11:7], 7'b1101111};
    end else begin
      // load opcode, not carried by this pipe
      inst = {f[31:7], 7'b0000011};
    end
    return inst;
  endfunction

  // present one word from a falling edge until the DUT takes it
  task automatic issue_insn(input logic [31:0] inst, input logic rand_stall);
    logic [31:0] r;
    logic        done;
    exp_t        e;
    done = 1'b0;
    r    = xorshift32();
    // occasional idle cycle
    if (r[2:0] == 3'd0) begin
      issue_valid_i = 1'b0;
      stall_i       = rand_stall & (r[4:3] == 2'b00);
      @(negedge clk);
    end
    pc_i          = next_pc;
    inst_i        = inst;
    rs1_data_i    = xorshift32();
    // equal operands now and then for beq and bne
    rs2_data_i    = (r[6:5] == 2'b00) ? rs1_data_i : xorshift32();
    issue_valid_i = 1'b1;
    e             = ref_model(pc_i, inst_i, rs1_data_i, rs2_data_i);
    while (!done) begin
      r       = xorshift32();
      stall_i = rand_stall & (r[1:0] == 2'b00);
      #2;
      // ready settled, accepted at the coming rising edge
      if (issue_ready_o) begin
        e.acc_edge   = cyc + 32'd1;
        e.stall_snap = stall_edges;
        if (e.valid) exp_q.push_back(e);
        done = 1'b1;
      end
      @(negedge clk);
    end
    issue_valid_i = 1'b0;
    next_pc       = next_pc + 32'd4;
  endtask

  // one sample per cycle, just before the rising edge
  task automatic check_cycle();
    exp_t e;
    if (prev_stall && prev_valid) begin
      if (!result_valid_o || rd_o != prev_rd || result_o != prev_result
          || res_pc_o != prev_pc) begin
        $display("error at %0t: result outputs changed while stalled", $time);
        n_value_err++;
      end
    end
    if (redirect_o) begin
      if (exp_q.size() == 0 || !exp_q[0].taken) begin
        $display("redirect raised at %0t with no taken branch pending", $time);
        n_other_err++;
      end else begin
        if (redirect_pc_o != exp_q[0].target) begin
          $display("error at %0t: redirect pc %h, expected %h", $time, redirect_pc_o,
                   exp_q[0].target);
          n_value_err++;
        end
        redirect_seen = 1'b1;
        // younger words were flushed at the edge just passed
        while (exp_q.size() > 1 && exp_q[1].acc_edge <= cyc) exp_q.delete(1);
      end
    end
    if (result_valid_o && !stall_i) begin
      if (exp_q.size() == 0) begin
        $display("result at %0t with no instruction outstanding", $time);
        n_other_err++;
      end else begin
        e = exp_q.pop_front();
        n_checked++;
        if (res_pc_o != e.pc) begin
          $display("error at %0t: result pc %h, expected %h", $time, res_pc_o, e.pc);
          n_value_err++;
        end else if (rd_o != e.rd || result_o != e.result) begin
          $display("error at %0t: pc %h gave rd %0d value %h, expected rd %0d value %h",
                   $time, e.pc, rd_o, result_o, e.rd, e.result);
          n_value_err++;
        end
        if (e.taken && !redirect_seen) begin
          $display("taken branch at pc %h finished without a redirect", e.pc);
          n_other_err++;
        end
        // exact latency only when no stall touched this word
        if (e.stall_snap == stall_edges && (cyc - e.acc_edge) != LATENCY) begin
          $display("error at %0t: pc %h took %0d edges, expected %0d", $time, e.pc,
                   cyc - e.acc_edge, LATENCY);
          n_value_err++;
        end
      end
      redirect_seen = 1'b0;
    end
    prev_valid  = result_valid_o;
    prev_stall  = stall_i;
    prev_rd     = rd_o;
    prev_result = result_o;
    prev_pc     = res_pc_o;
    if (stall_i) stall_edges = stall_edges + 32'd1;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      #5;
      if (!rst_i) check_cycle();
    end
  end

  // run length bound from the instruction count
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("simulation timed out after %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst_i         = 1'b1;
    issue_valid_i = 1'b0;
    pc_i          = '0;
    inst_i        = INST_NOP;
    rs1_data_i    = '0;
    rs2_data_i    = '0;
    stall_i       = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    if (result_valid_o || redirect_o) begin
      $display("result or redirect still high after reset");
      n_other_err++;
    end
    // empty pipe takes a word right away
    if (!issue_ready_o) begin
      $display("issue ready not raised in the first cycle after reset");
      n_other_err++;
    end
    // alu stream without back-pressure
    for (int i = 0; i < N_ALU; i++) begin
      issue_insn(make_inst(1'b1), 1'b0);
    end
    // full mix with branches and random stall
    for (int i = 0; i < N_MIX; i++) begin
      issue_insn(make_inst(1'b0), 1'b1);
    end
    issue_valid_i = 1'b0;
    stall_i       = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    // catch any stray result
    repeat (PIPE_DEPTH + 4) @(negedge clk);
    if (n_checked == 0) begin
      $display("no result was ever checked");
      n_other_err++;
    end
    $display("%0d results checked, %0d value errors, %0d other errors", n_checked,
             n_value_err, n_other_err);
    if (n_value_err == 0 && n_other_err == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/inst_decode.sv
source/pipe_stage_reg.sv
source/pipe_ctrl.sv
source/exec_unit.sv
source/core_pipe_top.sv
tb/core_pipe_props.sv
tb/core_pipe_tb.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_pipe_tb -f files.f -o sim_core_pipe

# status comes from the pass line in the output
out=$(./obj_dir/sim_core_pipe) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test OK'
